/* sources.f */
+incdir+include
verilog/rv_decode_pkg.sv
verilog/uop_decoder.sv
verilog/reg_file.sv
verilog/decode_regread.sv
verification/tb_decode_regread.sv

/* Bender.yml */
package:
  name: decode_regread

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/rv_decode_pkg.sv
      - verilog/uop_decoder.sv
      - verilog/reg_file.sv
      - verilog/decode_regread.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/tb_decode_regread.sv

/* verification/tb_decode_regread.sv */
// table-driven testbench for the decode and register-read stage
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module tb_decode_regread
    import rv_decode_pkg::*;
();

    localparam logic [2:0] IMM_NONE = 3'd0;
    localparam logic [2:0] IMM_I    = 3'd1;
    localparam logic [2:0] IMM_S    = 3'd2;
    localparam logic [2:0] IMM_B    = 3'd3;
    localparam logic [2:0] IMM_U    = 3'd4;
    localparam logic [2:0] IMM_J    = 3'd5;

    typedef struct packed {
        logic [`XLEN-1:0] word;
        logic             valid;
        logic             comp;
        uop_e             uop;
        logic [2:0]       imm_sel;
    } entry_t;

    logic                   clk_i;
    logic                   rst_i;
    logic [`XLEN-1:0]       instr_i;
    logic                   instr_valid_i;
    logic                   compressed_i;
    logic [`REG_ADDR_W-1:0] wb_addr_i;
    logic [`XLEN-1:0]       wb_data_i;
    logic                   wb_we_i;
    uop_e                   uop_o;
    logic [`REG_ADDR_W-1:0] rd_addr_o;
    logic [`XLEN-1:0]       rs1_data_o;
    logic [`XLEN-1:0]       rs2_data_o;
    logic [`XLEN-1:0]       imm_i_o;
    logic [`XLEN-1:0]       imm_s_o;
    logic [`XLEN-1:0]       imm_b_o;
    logic [`XLEN-1:0]       imm_u_o;
    logic [`XLEN-1:0]       imm_j_o;
    logic                   compressed_o;

    entry_t           stim_q [$];
    logic [`XLEN-1:0] reg_model [0:31];
    integer           seed;
    int               error_count;
    int               check_count;
    int               test_count;

    decode_regread UUT (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .compressed_i  (compressed_i),
        .wb_addr_i     (wb_addr_i),
        .wb_data_i     (wb_data_i),
        .wb_we_i       (wb_we_i),
        .uop_o         (uop_o),
        .rd_addr_o     (rd_addr_o),
        .rs1_data_o    (rs1_data_o),
        .rs2_data_o    (rs2_data_o),
        .imm_i_o       (imm_i_o),
        .imm_s_o       (imm_s_o),
        .imm_b_o       (imm_b_o),
        .imm_u_o       (imm_u_o),
        .imm_j_o       (imm_j_o),
        .compressed_o  (compressed_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // one instruction word builder per RV32I format
    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
    endfunction

    function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [6:0] op);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op};
    endfunction

    function automatic logic [31:0] u_word(input logic [19:0] imm, input logic [4:0] rd,
            input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_word(input logic [20:0] imm, input logic [4:0] rd,
            input logic [6:0] op);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
    endfunction

    // expected immediates straight from the instruction bit positions
    function automatic logic [31:0] sext_i(input logic [31:0] w);
        return {{21{w[31]}}, w[30:20]};
    endfunction

    function automatic logic [31:0] sext_s(input logic [31:0] w);
        return {{21{w[31]}}, w[30:25], w[11:7]};
    endfunction

    function automatic logic [31:0] b_offset(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    function automatic logic [31:0] u_upper(input logic [31:0] w);
        return {w[31:12], 12'b0};
    endfunction

    function automatic logic [31:0] j_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    task automatic add_entry(input logic [31:0] w, input logic c, input uop_e u,
            input logic [2:0] sel);
        stim_q.push_back('{word: w, valid: 1'b1, comp: c, uop: u, imm_sel: sel});
    endtask

    // valid low always decodes to the invalid operation
    task automatic add_bubble(input logic [31:0] w, input logic c);
        stim_q.push_back('{word: w, valid: 1'b0, comp: c, uop: UOP_INVALID, imm_sel: IMM_NONE});
    endtask

    task automatic load_table();
        add_entry(u_word(20'h12345, 5'd1, OP_LUI), 1'b0, UOP_LUI, IMM_U);
        add_entry(u_word(20'hfedcb, 5'd2, OP_LUI), 1'b1, UOP_LUI, IMM_U);
        add_entry(u_word(20'h80000, 5'd3, OP_AUIPC), 1'b0, UOP_AUIPC, IMM_U);
        add_entry(j_word(21'h000ffe, 5'd4, OP_JAL), 1'b0, UOP_JAL, IMM_J);
        add_entry(j_word(21'h1ffffc, 5'd0, OP_JAL), 1'b1, UOP_JAL, IMM_J);
        add_entry(j_word(21'h155554, 5'd6, OP_JAL), 1'b0, UOP_JAL, IMM_J);
        add_entry(i_word(12'hfff, 5'd2, 3'd0, 5'd1, OP_JALR), 1'b1, UOP_JALR, IMM_I);
        add_entry(b_word(13'h0ffe, 5'd2, 5'd1, 3'd0, OP_BRANCH), 1'b0, UOP_BEQ, IMM_B);
        add_entry(b_word(13'h1ffe, 5'd4, 5'd3, 3'd1, OP_BRANCH), 1'b0, UOP_BNE, IMM_B);
        add_entry(b_word(13'h0800, 5'd6, 5'd5, 3'd4, OP_BRANCH), 1'b1, UOP_BLT, IMM_B);
        add_entry(b_word(13'h1000, 5'd8, 5'd7, 3'd5, OP_BRANCH), 1'b0, UOP_BGE, IMM_B);
        add_entry(b_word(13'h0aaa, 5'd10, 5'd9, 3'd6, OP_BRANCH), 1'b0, UOP_BLTU, IMM_B);
        add_entry(b_word(13'h1554, 5'd12, 5'd11, 3'd7, OP_BRANCH), 1'b1, UOP_BGEU, IMM_B);
        add_entry(i_word(12'h7ff, 5'd1, 3'd0, 5'd2, OP_LOAD), 1'b0, UOP_LB, IMM_I);
        add_entry(i_word(12'h800, 5'd1, 3'd1, 5'd3, OP_LOAD), 1'b0, UOP_LH, IMM_I);
        add_entry(i_word(12'h004, 5'd1, 3'd2, 5'd4, OP_LOAD), 1'b1, UOP_LW, IMM_I);
        add_entry(i_word(12'hff0, 5'd1, 3'd4, 5'd5, OP_LOAD), 1'b0, UOP_LBU, IMM_I);
        add_entry(i_word(12'h123, 5'd1, 3'd5, 5'd6, OP_LOAD), 1'b0, UOP_LHU, IMM_I);
        add_entry(s_word(12'h7ff, 5'd3, 5'd1, 3'd0, OP_STORE), 1'b0, UOP_SB, IMM_S);
        add_entry(s_word(12'h800, 5'd3, 5'd1, 3'd1, OP_STORE), 1'b1, UOP_SH, IMM_S);
        add_entry(s_word(12'hfe1, 5'd3, 5'd1, 3'd2, OP_STORE), 1'b0, UOP_SW, IMM_S);
        add_entry(i_word(12'hfff, 5'd7, 3'd0, 5'd8, OP_IMM), 1'b0, UOP_ADDI, IMM_I);
        add_entry(i_word(12'h001, 5'd7, 3'd2, 5'd9, OP_IMM), 1'b0, UOP_SLTI, IMM_I);
        add_entry(i_word(12'h800, 5'd7, 3'd3, 5'd10, OP_IMM), 1'b1, UOP_SLTIU, IMM_I);
        add_entry(i_word(12'h555, 5'd7, 3'd4, 5'd11, OP_IMM), 1'b0, UOP_XORI, IMM_I);
        add_entry(i_word(12'haaa, 5'd7, 3'd6, 5'd12, OP_IMM), 1'b0, UOP_ORI, IMM_I);
        add_entry(i_word(12'h0ff, 5'd7, 3'd7, 5'd13, OP_IMM), 1'b0, UOP_ANDI, IMM_I);
        add_entry(i_word({7'h00, 5'd31}, 5'd1, 3'd1, 5'd2, OP_IMM), 1'b0, UOP_SLLI, IMM_I);
        add_entry(i_word({7'h00, 5'd1}, 5'd1, 3'd5, 5'd2, OP_IMM), 1'b1, UOP_SRLI, IMM_I);
        add_entry(i_word({7'h20, 5'd7}, 5'd1, 3'd5, 5'd2, OP_IMM), 1'b0, UOP_SRAI, IMM_I);
        add_entry(r_word(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, OP_REG), 1'b0, UOP_ADD, IMM_NONE);
        add_entry(r_word(7'h20, 5'd3, 5'd2, 3'd0, 5'd14, OP_REG), 1'b1, UOP_SUB, IMM_NONE);
        add_entry(r_word(7'h00, 5'd3, 5'd2, 3'd1, 5'd15, OP_REG), 1'b0, UOP_SLL, IMM_NONE);
        add_entry(r_word(7'h00, 5'd3, 5'd2, 3'd2, 5'd16, OP_REG), 1'b0, UOP_SLT, IMM_NONE);
        add_entry(r_word(7'h00, 5'd3, 5'd2, 3'd3, 5'd17, OP_REG), 1'b0, UOP_SLTU, IMM_NONE);
        add_entry(r_word(7'h00, 5'd3, 5'd2, 3'd4, 5'd18, OP_REG), 1'b1, UOP_XOR, IMM_NONE);
        add_entry(r_word(7'h00, 5'd3, 5'd2, 3'd5, 5'd19, OP_REG), 1'b0, UOP_SRL, IMM_NONE);
        add_entry(r_word(7'h20, 5'd3, 5'd2, 3'd5, 5'd20, OP_REG), 1'b0, UOP_SRA, IMM_NONE);
        add_entry(r_word(7'h00, 5'd3, 5'd2, 3'd6, 5'd21, OP_REG), 1'b0, UOP_OR, IMM_NONE);
        add_entry(r_word(7'h00, 5'd3, 5'd2, 3'd7, 5'd22, OP_REG), 1'b1, UOP_AND, IMM_NONE);
        add_entry(r_word(7'h01, 5'd5, 5'd4, 3'd0, 5'd23, OP_REG), 1'b0, UOP_MUL, IMM_NONE);
        add_entry(r_word(7'h01, 5'd5, 5'd4, 3'd1, 5'd24, OP_REG), 1'b0, UOP_MULH, IMM_NONE);
        add_entry(r_word(7'h01, 5'd5, 5'd4, 3'd2, 5'd25, OP_REG), 1'b1, UOP_MULHSU, IMM_NONE);
        add_entry(r_word(7'h01, 5'd5, 5'd4, 3'd3, 5'd26, OP_REG), 1'b0, UOP_MULHU, IMM_NONE);
        add_entry(r_word(7'h01, 5'd5, 5'd4, 3'd4, 5'd27, OP_REG), 1'b0, UOP_DIV, IMM_NONE);
        add_entry(r_word(7'h01, 5'd5, 5'd4, 3'd5, 5'd28, OP_REG), 1'b0, UOP_DIVU, IMM_NONE);
        add_entry(r_word(7'h01, 5'd5, 5'd4, 3'd6, 5'd29, OP_REG), 1'b1, UOP_REM, IMM_NONE);
        add_entry(r_word(7'h01, 5'd5, 5'd4, 3'd7, 5'd30, OP_REG), 1'b0, UOP_REMU, IMM_NONE);
        add_entry(i_word(12'h0ff, 5'd0, 3'd0, 5'd0, OP_FENCE), 1'b0, UOP_FENCE, IMM_NONE);
        add_entry(i_word(12'h000, 5'd0, 3'd1, 5'd0, OP_FENCE), 1'b0, UOP_FENCE_I, IMM_NONE);
        add_entry(i_word(12'h000, 5'd0, 3'd0, 5'd0, OP_SYSTEM), 1'b1, UOP_ECALL, IMM_NONE);
        add_entry(i_word(12'h001, 5'd0, 3'd0, 5'd0, OP_SYSTEM), 1'b0, UOP_EBREAK, IMM_NONE);
        // encodings outside the supported set
        add_entry(i_word({7'h21, 5'd3}, 5'd1, 3'd5, 5'd2, OP_IMM), 1'b0, UOP_INVALID, IMM_NONE);
        add_entry(r_word(7'h20, 5'd2, 5'd1, 3'd1, 5'd3, OP_REG), 1'b0, UOP_INVALID, IMM_NONE);
        add_entry(i_word(12'h000, 5'd0, 3'd0, 5'd1, OP_SYSTEM), 1'b1, UOP_INVALID, IMM_NONE);
        add_entry(i_word(12'h300, 5'd1, 3'd1, 5'd2, OP_SYSTEM), 1'b0, UOP_INVALID, IMM_NONE);
        add_entry(b_word(13'h0010, 5'd2, 5'd1, 3'd2, OP_BRANCH), 1'b0, UOP_INVALID, IMM_NONE);
        add_entry(i_word(12'h000, 5'd1, 3'd3, 5'd2, OP_LOAD), 1'b0, UOP_INVALID, IMM_NONE);
        add_entry(s_word(12'h000, 5'd2, 5'd1, 3'd3, OP_STORE), 1'b1, UOP_INVALID, IMM_NONE);
        add_entry(i_word(12'h000, 5'd1, 3'd1, 5'd2, OP_JALR), 1'b0, UOP_INVALID, IMM_NONE);
        add_entry(32'hffff_ffff, 1'b0, UOP_INVALID, IMM_NONE);
        add_entry(32'h0000_0000, 1'b0, UOP_INVALID, IMM_NONE);
        add_bubble(r_word(7'h00, 5'd3, 5'd2, 3'd0, 5'd1, OP_REG), 1'b0);
        add_bubble(u_word(20'h12345, 5'd9, OP_LUI), 1'b1);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
            input logic [31:0] act, input int step);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("mismatch %s expected %h got %h at step %0d", name, exp, act, step);
        end
    endtask

    task automatic drive_instr(input logic [31:0] w, input logic v, input logic c);
        instr_i       = w;
        instr_valid_i = v;
        compressed_i  = c;
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        $display("test %s finished with %0d errors", name, error_count - errs_before);
    endtask

    // sampled before any edge without reset has passed
    task automatic run_reset_test();
        int errs_before;
        errs_before = error_count;
        check_value("uop_o", UOP_INVALID, uop_o, 0);
        check_value("rd_addr_o", '0, rd_addr_o, 0);
        check_value("rs1_data_o", '0, rs1_data_o, 0);
        check_value("rs2_data_o", '0, rs2_data_o, 0);
        check_value("imm_i_o", '0, imm_i_o, 0);
        check_value("imm_s_o", '0, imm_s_o, 0);
        check_value("imm_b_o", '0, imm_b_o, 0);
        check_value("imm_u_o", '0, imm_u_o, 0);
        check_value("imm_j_o", '0, imm_j_o, 0);
        check_value("compressed_o", '0, compressed_o, 0);
        report_test("reset", errs_before);
    endtask

    // entries go in one per cycle and each is checked on the next falling edge
    task automatic run_table_test();
        int errs_before;
        entry_t e;
        errs_before = error_count;
        for (int i = 0; i < stim_q.size(); i++) begin
            e = stim_q[i];
            drive_instr(e.word, e.valid, e.comp);
            @(negedge clk_i);
            check_value("uop_o", e.uop, uop_o, i);
            check_value("rd_addr_o", e.word[11:7], rd_addr_o, i);
            check_value("compressed_o", e.comp, compressed_o, i);
            case (e.imm_sel)
                IMM_I: check_value("imm_i_o", sext_i(e.word), imm_i_o, i);
                IMM_S: check_value("imm_s_o", sext_s(e.word), imm_s_o, i);
                IMM_B: check_value("imm_b_o", b_offset(e.word), imm_b_o, i);
                IMM_U: check_value("imm_u_o", u_upper(e.word), imm_u_o, i);
                IMM_J: check_value("imm_j_o", j_offset(e.word), imm_j_o, i);
                default: ;
            endcase
        end
        drive_instr('0, 1'b0, 1'b0);
        report_test("decode and immediates", errs_before);
    endtask

    task automatic run_regfile_test();
        int errs_before;
        logic [31:0] value;
        logic [4:0] ra;
        logic [4:0] rb;
        errs_before = error_count;
        // x0 gets a write too and must still read zero
        for (int r = 0; r < 32; r++) begin
            value     = $random(seed);
            wb_we_i   = 1'b1;
            wb_addr_i = r[4:0];
            wb_data_i = value;
            if (r != 0) begin
                reg_model[r] = value;
            end
            @(negedge clk_i);
        end
        wb_we_i = 1'b0;
        for (int r = 0; r < 32; r++) begin
            ra = r[4:0];
            rb = ra + 5'd1;
            drive_instr(r_word(7'h00, rb, ra, 3'd0, ra, OP_REG), 1'b1, 1'b0);
            @(negedge clk_i);
            check_value("uop_o", UOP_ADD, uop_o, r);
            check_value("rs1_data_o", reg_model[ra], rs1_data_o, r);
            check_value("rs2_data_o", reg_model[rb], rs2_data_o, r);
        end
        drive_instr('0, 1'b0, 1'b0);
        report_test("register write and read", errs_before);
    endtask

    task automatic run_writethrough_test();
        int errs_before;
        logic [31:0] value;
        logic [4:0] wt_regs [0:3];
        errs_before = error_count;
        wt_regs[0] = 5'd5;
        wt_regs[1] = 5'd17;
        wt_regs[2] = 5'd31;
        wt_regs[3] = 5'd0;
        for (int k = 0; k < 4; k++) begin
            value     = $random(seed);
            wb_we_i   = 1'b1;
            wb_addr_i = wt_regs[k];
            wb_data_i = value;
            drive_instr(r_word(7'h00, wt_regs[k], wt_regs[k], 3'd0, 5'd1, OP_REG), 1'b1, 1'b0);
            if (wt_regs[k] != 5'd0) begin
                reg_model[wt_regs[k]] = value;
            end
            @(negedge clk_i);
            check_value("rs1_data_o", reg_model[wt_regs[k]], rs1_data_o, k);
            check_value("rs2_data_o", reg_model[wt_regs[k]], rs2_data_o, k);
        end
        wb_we_i = 1'b0;
        drive_instr('0, 1'b0, 1'b0);
        report_test("write-through", errs_before);
    endtask

    initial begin
        seed          = 32'h97af_968a;
        error_count   = 0;
        check_count   = 0;
        test_count    = 0;
        rst_i         = 1'b1;
        instr_i       = '0;
        instr_valid_i = 1'b0;
        compressed_i  = 1'b0;
        wb_addr_i     = '0;
        wb_data_i     = '0;
        wb_we_i       = 1'b0;
        for (int r = 0; r < 32; r++) begin
            reg_model[r] = '0;
        end
        load_table();

        repeat (4) @(negedge clk_i);
        rst_i = 1'b0;
        run_reset_test();
        run_table_test();
        run_regfile_test();
        run_writethrough_test();

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/decode_regread.sv */
// decode and register-read stage, decoder and register file wired together
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module decode_regread
    import rv_decode_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,

    input  wire logic [`XLEN-1:0]       instr_i,
    input  wire logic                   instr_valid_i,
    input  wire logic                   compressed_i,

    // write-back from a later stage
    input  wire logic [`REG_ADDR_W-1:0] wb_addr_i,
    input  wire logic [`XLEN-1:0]       wb_data_i,
    input  wire logic                   wb_we_i,

    output uop_e                        uop_o,
    output logic [`REG_ADDR_W-1:0]      rd_addr_o,
    output logic [`XLEN-1:0]            rs1_data_o,
    output logic [`XLEN-1:0]            rs2_data_o,
    output logic [`XLEN-1:0]            imm_i_o,
    output logic [`XLEN-1:0]            imm_s_o,
    output logic [`XLEN-1:0]            imm_b_o,
    output logic [`XLEN-1:0]            imm_u_o,
    output logic [`XLEN-1:0]            imm_j_o,
    output logic                        compressed_o
);

    instr_fmt_u               instr_w;
    logic [`REG_ADDR_W-1:0]   rs1_addr_w;
    logic [`REG_ADDR_W-1:0]   rs2_addr_w;

    assign instr_w = instr_fmt_u'(instr_i);

    uop_decoder u_decoder (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .instr_i       (instr_w),
        .instr_valid_i (instr_valid_i),
        .compressed_i  (compressed_i),
        .rs1_addr_o    (rs1_addr_w),
        .rs2_addr_o    (rs2_addr_w),
        .uop_o         (uop_o),
        .rd_addr_o     (rd_addr_o),
        .imm_i_o       (imm_i_o),
        .imm_s_o       (imm_s_o),
        .imm_b_o       (imm_b_o),
        .imm_u_o       (imm_u_o),
        .imm_j_o       (imm_j_o),
        .compressed_o  (compressed_o)
    );

    // reads start on the same edge the decoder registers its result
    reg_file #(
        .NUM_REGS (`REG_COUNT)
    ) u_reg_file (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd1_addr_i (rs1_addr_w),
        .rd2_addr_i (rs2_addr_w),
        .rd1_data_o (rs1_data_o),
        .rd2_data_o (rs2_data_o),
        .wr_addr_i  (wb_addr_i),
        .wr_data_i  (wb_data_i),
        .wr_en_i    (wb_we_i)
    );

endmodule

`default_nettype wire

/* verilog/reg_file.sv */
// register file with two synchronous read ports, one write port and write-through
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module reg_file #(
    parameter int NUM_REGS = `REG_COUNT
) (
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,

    input  wire logic [`REG_ADDR_W-1:0] rd1_addr_i,
    input  wire logic [`REG_ADDR_W-1:0] rd2_addr_i,
    output logic [`XLEN-1:0]            rd1_data_o,
    output logic [`XLEN-1:0]            rd2_data_o,

    input  wire logic [`REG_ADDR_W-1:0] wr_addr_i,
    input  wire logic [`XLEN-1:0]       wr_data_i,
    input  wire logic                   wr_en_i
);

    // x0 has no storage
    logic [`XLEN-1:0] regs_q [1:NUM_REGS-1];
    logic             wr_hit;

    assign wr_hit = wr_en_i && (wr_addr_i != '0) && (wr_addr_i < NUM_REGS);

    // value a read port captures this edge, the pending write wins
    function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0 || addr >= NUM_REGS) begin
            return '0;
        end else if (wr_hit && wr_addr_i == addr) begin
            return wr_data_i;
        end
        return regs_q[addr];
    endfunction

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd1_data_o <= '0;
            rd2_data_o <= '0;
            for (int i = 1; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (wr_hit) begin
                regs_q[wr_addr_i] <= wr_data_i;
            end
            rd1_data_o <= read_port(rd1_addr_i);
            rd2_data_o <= read_port(rd2_addr_i);
        end
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        rd1_addr_i == '0 |=> rd1_data_o == '0);
    assert property (@(posedge clk_i) disable iff (rst_i)
        rd2_addr_i == '0 |=> rd2_data_o == '0);

    // write-back must never name a register an RV32E file lacks
    assert property (@(posedge clk_i) disable iff (rst_i)
        wr_en_i |-> wr_addr_i < NUM_REGS);

endmodule

`default_nettype wire

/* verilog/uop_decoder.sv */
// instruction decoder producing registered micro-operation, destination and immediates
`timescale 1ns/1ps
`default_nettype none

`include "decode_settings.svh"

module uop_decoder
    import rv_decode_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_i,

    input  wire instr_fmt_u             instr_i,
    input  wire logic                   instr_valid_i,
    input  wire logic                   compressed_i,

    // source addresses go straight to the register file read ports
    output logic [`REG_ADDR_W-1:0]      rs1_addr_o,
    output logic [`REG_ADDR_W-1:0]      rs2_addr_o,

    output uop_e                        uop_o,
    output logic [`REG_ADDR_W-1:0]      rd_addr_o,
    output logic [`XLEN-1:0]            imm_i_o,
    output logic [`XLEN-1:0]            imm_s_o,
    output logic [`XLEN-1:0]            imm_b_o,
    output logic [`XLEN-1:0]            imm_u_o,
    output logic [`XLEN-1:0]            imm_j_o,
    output logic                        compressed_o
);

    logic [16:0]        key;
    logic               sys_zero;
    uop_e               uop_d;
    logic [`XLEN-1:0]   imm_i_d;
    logic [`XLEN-1:0]   imm_s_d;
    logic [`XLEN-1:0]   imm_b_d;
    logic [`XLEN-1:0]   imm_u_d;
    logic [`XLEN-1:0]   imm_j_d;

    assign rs1_addr_o = instr_i.r_type.rs1;
    assign rs2_addr_o = instr_i.r_type.rs2;

    // funct7, funct3 and opcode are enough to tell everything apart except the system group
    assign key = {instr_i.r_type.funct7, instr_i.r_type.funct3, instr_i.r_type.opcode};

    // ecall and ebreak need rs1 and rd zero
    assign sys_zero = (instr_i.r_type.rs1 == 5'd0) && (instr_i.r_type.rd == 5'd0);

    // immediates, sign taken from bit 31 in every format
    assign imm_i_d = {{(`XLEN-12){instr_i.i_type.imm[11]}}, instr_i.i_type.imm};
    assign imm_s_d = {{(`XLEN-12){instr_i.s_type.imm_hi[6]}},
                      instr_i.s_type.imm_hi, instr_i.s_type.imm_lo};
    assign imm_b_d = {{(`XLEN-13){instr_i.b_type.imm12}}, instr_i.b_type.imm12,
                      instr_i.b_type.imm11, instr_i.b_type.imm10_5,
                      instr_i.b_type.imm4_1, 1'b0};
    assign imm_u_d = {instr_i.u_type.imm, 12'b0};
    assign imm_j_d = {{(`XLEN-21){instr_i.j_type.imm20}}, instr_i.j_type.imm20,
                      instr_i.j_type.imm19_12, instr_i.j_type.imm11,
                      instr_i.j_type.imm10_1, 1'b0};

    // most specific patterns first, wildcards last
    always_comb begin
        uop_d = UOP_INVALID;
        casez (key)
            // register-register, base and M extension
            {7'b0000000, 3'b000, OP_REG}: uop_d = UOP_ADD;
            {7'b0100000, 3'b000, OP_REG}: uop_d = UOP_SUB;
            {7'b0000000, 3'b001, OP_REG}: uop_d = UOP_SLL;
            {7'b0000000, 3'b010, OP_REG}: uop_d = UOP_SLT;
            {7'b0000000, 3'b011, OP_REG}: uop_d = UOP_SLTU;
            {7'b0000000, 3'b100, OP_REG}: uop_d = UOP_XOR;
            {7'b0000000, 3'b101, OP_REG}: uop_d = UOP_SRL;
            {7'b0100000, 3'b101, OP_REG}: uop_d = UOP_SRA;
            {7'b0000000, 3'b110, OP_REG}: uop_d = UOP_OR;
            {7'b0000000, 3'b111, OP_REG}: uop_d = UOP_AND;
            {7'b0000001, 3'b000, OP_REG}: uop_d = UOP_MUL;
            {7'b0000001, 3'b001, OP_REG}: uop_d = UOP_MULH;
            {7'b0000001, 3'b010, OP_REG}: uop_d = UOP_MULHSU;
            {7'b0000001, 3'b011, OP_REG}: uop_d = UOP_MULHU;
            {7'b0000001, 3'b100, OP_REG}: uop_d = UOP_DIV;
            {7'b0000001, 3'b101, OP_REG}: uop_d = UOP_DIVU;
            {7'b0000001, 3'b110, OP_REG}: uop_d = UOP_REM;
            {7'b0000001, 3'b111, OP_REG}: uop_d = UOP_REMU;

            // shifts by immediate, shamt[5] set is illegal on rv32
            {7'b0000000, 3'b001, OP_IMM}: uop_d = UOP_SLLI;
            {7'b0000000, 3'b101, OP_IMM}: uop_d = UOP_SRLI;
            {7'b0100000, 3'b101, OP_IMM}: uop_d = UOP_SRAI;

            {7'b0000000, 3'b000, OP_SYSTEM}: begin
                if (sys_zero && instr_i.r_type.rs2 == 5'd0) begin
                    uop_d = UOP_ECALL;
                end else if (sys_zero && instr_i.r_type.rs2 == 5'd1) begin
                    uop_d = UOP_EBREAK;
                end
            end

            // register-immediate
            {7'b???????, 3'b000, OP_IMM}: uop_d = UOP_ADDI;
            {7'b???????, 3'b010, OP_IMM}: uop_d = UOP_SLTI;
            {7'b???????, 3'b011, OP_IMM}: uop_d = UOP_SLTIU;
            {7'b???????, 3'b100, OP_IMM}: uop_d = UOP_XORI;
            {7'b???????, 3'b110, OP_IMM}: uop_d = UOP_ORI;
            {7'b???????, 3'b111, OP_IMM}: uop_d = UOP_ANDI;

            {7'b???????, 3'b000, OP_LOAD}: uop_d = UOP_LB;
            {7'b???????, 3'b001, OP_LOAD}: uop_d = UOP_LH;
            {7'b???????, 3'b010, OP_LOAD}: uop_d = UOP_LW;
            {7'b???????, 3'b100, OP_LOAD}: uop_d = UOP_LBU;
            {7'b???????, 3'b101, OP_LOAD}: uop_d = UOP_LHU;

            {7'b???????, 3'b000, OP_STORE}: uop_d = UOP_SB;
            {7'b???????, 3'b001, OP_STORE}: uop_d = UOP_SH;
            {7'b???????, 3'b010, OP_STORE}: uop_d = UOP_SW;

            {7'b???????, 3'b000, OP_BRANCH}: uop_d = UOP_BEQ;
            {7'b???????, 3'b001, OP_BRANCH}: uop_d = UOP_BNE;
            {7'b???????, 3'b100, OP_BRANCH}: uop_d = UOP_BLT;
            {7'b???????, 3'b101, OP_BRANCH}: uop_d = UOP_BGE;
            {7'b???????, 3'b110, OP_BRANCH}: uop_d = UOP_BLTU;
            {7'b???????, 3'b111, OP_BRANCH}: uop_d = UOP_BGEU;

            // fence fields other than funct3 are hints, ignored here
            {7'b???????, 3'b000, OP_FENCE}: uop_d = UOP_FENCE;
            {7'b???????, 3'b001, OP_FENCE}: uop_d = UOP_FENCE_I;

            {7'b???????, 3'b000, OP_JALR}: uop_d = UOP_JALR;

            // u and j formats have no funct fields at all
            {7'b???????, 3'b???, OP_JAL}:   uop_d = UOP_JAL;
            {7'b???????, 3'b???, OP_LUI}:   uop_d = UOP_LUI;
            {7'b???????, 3'b???, OP_AUIPC}: uop_d = UOP_AUIPC;

            default: uop_d = UOP_INVALID;
        endcase

        if (!instr_valid_i) begin
            uop_d = UOP_INVALID;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            uop_o        <= UOP_INVALID;
            rd_addr_o    <= '0;
            imm_i_o      <= '0;
            imm_s_o      <= '0;
            imm_b_o      <= '0;
            imm_u_o      <= '0;
            imm_j_o      <= '0;
            compressed_o <= 1'b0;
        end else begin
            uop_o        <= uop_d;
            rd_addr_o    <= instr_i.r_type.rd;
            imm_i_o      <= imm_i_d;
            imm_s_o      <= imm_s_d;
            imm_b_o      <= imm_b_d;
            imm_u_o      <= imm_u_d;
            imm_j_o      <= imm_j_d;
            compressed_o <= compressed_i;
        end
    end

    // a bubble never turns into a real operation downstream
    assert property (@(posedge clk_i) disable iff (rst_i)
        !instr_valid_i |=> uop_o == UOP_INVALID);

endmodule

`default_nettype wire

/* verilog/rv_decode_pkg.sv */
// instruction format union, micro-operation enumeration and RV32 opcode constants
`default_nettype none

`include "decode_settings.svh"

package rv_decode_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    // branch offset is scattered over the s-type immediate slots
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // one instruction word, six ways to read it
    typedef union packed {
        r_type_t r_type;
        i_type_t i_type;
        s_type_t s_type;
        b_type_t b_type;
        u_type_t u_type;
        j_type_t j_type;
    } instr_fmt_u;

    typedef enum logic [5:0] {
        UOP_INVALID = 6'd0,
        UOP_LUI, UOP_AUIPC, UOP_JAL, UOP_JALR,
        UOP_BEQ, UOP_BNE, UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU,
        UOP_LB, UOP_LH, UOP_LW, UOP_LBU, UOP_LHU,
        UOP_SB, UOP_SH, UOP_SW,
        UOP_ADDI, UOP_SLTI, UOP_SLTIU, UOP_XORI, UOP_ORI, UOP_ANDI,
        UOP_SLLI, UOP_SRLI, UOP_SRAI,
        UOP_ADD, UOP_SUB, UOP_SLL, UOP_SLT, UOP_SLTU,
        UOP_XOR, UOP_SRL, UOP_SRA, UOP_OR, UOP_AND,
        UOP_FENCE, UOP_FENCE_I, UOP_ECALL, UOP_EBREAK,
        UOP_MUL, UOP_MULH, UOP_MULHSU, UOP_MULHU,
        UOP_DIV, UOP_DIVU, UOP_REM, UOP_REMU
    } uop_e;

    // major opcodes, low two bits are always 11 for 32-bit words
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_FENCE  = 7'b0001111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

endpackage

`default_nettype wire

/* include/decode_settings.svh */
// data width, register count and register address width of the decode stage
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// instruction and data word width
`define XLEN 32

// architectural registers, 16 gives an RV32E file
`define REG_COUNT 32

// register address field width in the instruction word
`define REG_ADDR_W 5

`endif
